// ==== sim.f ====
regBistPkg.sv
regPortIf.sv
regFile.sv
bistSequencer.sv
bistChecker.sv
axiLiteRegPort.sv
regBistTop.sv
tbRegBist.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the register file self-test testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps -f sim.f --top-module tbRegBist
./obj_dir/VtbRegBist | tee sim.log
if grep -q "Simulation finished: PASS" sim.log; then
  echo "run.sh: simulation passed"
  exit 0
fi
echo "run.sh: simulation failed"
exit 1

// ==== tbRegBist.sv ====
//------------------------------------------------
// Testbench for the register file self-test
// Table-driven AXI4-Lite traffic, status polling
//------------------------------------------------

module tbRegBist;
  timeunit 1ns;
  timeprecision 1ps;

  import regBistPkg::*;

  localparam int passCount   = 2;
  localparam int waitLimit   = 50;
  localparam int pollLimit   = 400;

  // Kinds of table step
  typedef enum logic [1:0] {
    axWrite,
    axRead,
    axStatus
  } stepKindE;

  typedef struct packed {
    stepKindE            kind;
    logic [axiAddrW-1:0] addr;
    regDataT             data;
    logic [3:0]          strb;
    axiRespE             resp;
    regDataT             expData;
  } stepS;

  logic                begintest;
  logic                rstN;
  logic                awvalid;
  logic [axiAddrW-1:0] awaddr;
  logic                awready;
  logic                wvalid;
  regDataT             wdata;
  logic [3:0]          wstrb;
  logic                wready;
  logic                bvalid;
  logic                bready;
  axiRespE             bresp;
  logic                arvalid;
  logic [axiAddrW-1:0] araddr;
  logic                arready;
  logic                rvalid;
  logic                rready;
  regDataT             rdata;
  axiRespE             rresp;

  stepS        steps[$];
  regDataT     model [0:31];
  logic [31:0] lfsrState;
  logic [31:0] status;

  regBistTop #(
    .passCount (passCount)
  ) dut0 (
    .begintest (begintest), .rstN (rstN),
    .awvalid (awvalid), .awaddr (awaddr), .awready (awready),
    .wvalid (wvalid), .wdata (wdata), .wstrb (wstrb), .wready (wready),
    .bvalid (bvalid), .bready (bready), .bresp (bresp),
    .arvalid (arvalid), .araddr (araddr), .arready (arready),
    .rvalid (rvalid), .rready (rready), .rdata (rdata), .rresp (rresp)
  );

  initial begin
    begintest = 1'b0;
    forever #2 begintest = ~begintest;
  end

  // ------------------------------------------------
  // Reporting and checks
  // ------------------------------------------------

  task automatic endWithFail();
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic checkResp(string name, axiRespE got, axiRespE exp);
    if (got !== exp) begin
      $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
      endWithFail();
    end
  endtask

  task automatic checkData(string name, regDataT got, regDataT exp);
    if (got !== exp) begin
      $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
      endWithFail();
    end
  endtask

  task automatic checkStatus(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
      endWithFail();
    end
  endtask

  task automatic checkFlag(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("Error at %0t: %s got %b expected %b", $time, name, got, exp);
      endWithFail();
    end
  endtask

  // ------------------------------------------------
  // Stimulus helpers
  // ------------------------------------------------

  // Galois LFSR stepped once per bit
  function automatic regDataT randWord();
    regDataT word;
    word = '0;
    for (int b = 0; b < 32; b++) begin
      word      = {word[30:0], lfsrState[0]};
      lfsrState = (lfsrState >> 1) ^ (lfsrState[0] ? 32'h8020_0003 : 32'h0);
    end
    return word;
  endfunction

  function automatic logic [axiAddrW-1:0] regByteAddr(int r);
    return axiAddrW'(r * 4);
  endfunction

  // Index in every byte of the pass p pattern and inverted on odd passes
  function automatic regDataT passWord(int r, int p);
    regDataT word;
    for (int b = 0; b < 4; b++) begin
      word[b*8 +: 8] = 8'(r);
    end
    return (p % 2 == 1) ? ~word : word;
  endfunction

  function automatic logic [31:0] makeStatus(logic busy, logic done, logic ok, int fails);
    return {16'h0, 8'(fails), 5'b0, ok, done, busy};
  endfunction

  task automatic addStep(stepKindE kind, logic [axiAddrW-1:0] addr, regDataT data,
                         logic [3:0] strb, axiRespE resp, regDataT expData);
    stepS s;
    s.kind    = kind;
    s.addr    = addr;
    s.data    = data;
    s.strb    = strb;
    s.resp    = resp;
    s.expData = expData;
    steps.push_back(s);
  endtask

  // Address and data go out together and drop on their own handshakes
  task automatic axiWrite(logic [axiAddrW-1:0] addr, regDataT data, logic [3:0] strb,
                          output axiRespE resp);
    int   waitCnt;
    logic awGo;
    logic wGo;
    @(negedge begintest);
    awvalid = 1'b1;
    awaddr  = addr;
    wvalid  = 1'b1;
    wdata   = data;
    wstrb   = strb;
    bready  = 1'b1;
    waitCnt = 0;
    while (awvalid || wvalid) begin
      awGo = awready;
      wGo  = wready;
      @(negedge begintest);
      if (awGo) begin
        awvalid = 1'b0;
      end
      if (wGo) begin
        wvalid = 1'b0;
      end
      waitCnt++;
      if (waitCnt > waitLimit) begin
        $display("Write address or data was never accepted at %0t", $time);
        endWithFail();
      end
    end
    waitCnt = 0;
    while (!bvalid) begin
      waitCnt++;
      if (waitCnt > waitLimit) begin
        $display("Write response never arrived at %0t", $time);
        endWithFail();
      end
      @(negedge begintest);
    end
    resp = bresp;
    // No new write accepted while the response is pending
    checkFlag("awready", awready, 1'b0);
    checkFlag("wready", wready, 1'b0);
    @(negedge begintest);
    bready = 1'b0;
  endtask

  task automatic axiRead(logic [axiAddrW-1:0] addr, output regDataT data,
                         output axiRespE resp);
    int waitCnt;
    @(negedge begintest);
    arvalid = 1'b1;
    araddr  = addr;
    rready  = 1'b1;
    waitCnt = 0;
    while (!arready) begin
      waitCnt++;
      if (waitCnt > waitLimit) begin
        $display("Read address was never accepted at %0t", $time);
        endWithFail();
      end
      @(negedge begintest);
    end
    @(negedge begintest);
    arvalid = 1'b0;
    waitCnt = 0;
    while (!rvalid) begin
      waitCnt++;
      if (waitCnt > waitLimit) begin
        $display("Read data never arrived at %0t", $time);
        endWithFail();
      end
      @(negedge begintest);
    end
    data = rdata;
    resp = rresp;
    // No new read accepted while data is pending
    checkFlag("arready", arready, 1'b0);
    @(negedge begintest);
    rready = 1'b0;
  endtask

  // Apply every queued step, then empty the table
  task automatic runSteps();
    regDataT gotData;
    axiRespE gotResp;
    foreach (steps[i]) begin
      if (steps[i].kind == axWrite) begin
        axiWrite(steps[i].addr, steps[i].data, steps[i].strb, gotResp);
        checkResp($sformatf("bresp at %h", steps[i].addr), gotResp, steps[i].resp);
      end else begin
        axiRead(steps[i].addr, gotData, gotResp);
        checkResp($sformatf("rresp at %h", steps[i].addr), gotResp, steps[i].resp);
        if (steps[i].kind == axStatus) begin
          checkStatus("status", gotData, steps[i].expData);
        end else begin
          checkData($sformatf("rdata at %h", steps[i].addr), gotData, steps[i].expData);
        end
      end
    end
    steps.delete();
  endtask

  task automatic waitForDone(output logic [31:0] word);
    regDataT got;
    axiRespE resp;
    int      polls;
    polls = 0;
    got   = '0;
    while (got[1] == 1'b0) begin
      if (polls == pollLimit) begin
        $display("Self-test did not report done within %0d status polls", pollLimit);
        endWithFail();
      end
      axiRead(statusAddr, got, resp);
      checkResp("rresp at status", resp, respOkay);
      polls++;
    end
    word = got;
  endtask

  // One self-test run with host traffic while it is busy
  task automatic runSelfTest();
    addStep(axWrite, ctrlAddr, 32'h1, 4'hf, respOkay, '0);
    addStep(axStatus, statusAddr, '0, 4'hf, respOkay, makeStatus(1'b1, 1'b0, 1'b0, 0));
    addStep(axRead, regByteAddr(3), '0, 4'hf, respSlvErr, '0);
    addStep(axWrite, regByteAddr(3), randWord(), 4'hf, respSlvErr, '0);
    addStep(axRead, regByteAddr(17), '0, 4'hf, respSlvErr, '0);
    runSteps();
    waitForDone(status);
    checkStatus("status after test", status, makeStatus(1'b0, 1'b1, 1'b1, 0));
  endtask

  // ------------------------------------------------
  // Main sequence
  // ------------------------------------------------

  initial begin
    rstN      = 1'b0;
    awvalid   = 1'b0;
    awaddr    = '0;
    wvalid    = 1'b0;
    wdata     = '0;
    wstrb     = '0;
    bready    = 1'b0;
    arvalid   = 1'b0;
    araddr    = '0;
    rready    = 1'b0;
    lfsrState = 32'h320c_6ec7;
    for (int r = 0; r < 32; r++) begin
      model[r] = '0;
    end
    repeat (16) @(posedge begintest);
    @(negedge begintest);
    rstN = 1'b1;

    // Idle AXI handshake after reset
    checkFlag("awready", awready, 1'b1);
    checkFlag("wready", wready, 1'b1);
    checkFlag("arready", arready, 1'b1);
    checkFlag("bvalid", bvalid, 1'b0);
    checkFlag("rvalid", rvalid, 1'b0);

    // Clean state after reset
    addStep(axStatus, statusAddr, '0, 4'hf, respOkay, makeStatus(1'b0, 1'b0, 1'b0, 0));
    for (int r = 1; r < 32; r++) begin
      addStep(axRead, regByteAddr(r), '0, 4'hf, respOkay, '0);
    end
    runSteps();

    // Host data through every register while register 0 stays zero
    for (int r = 1; r < 32; r++) begin
      model[r] = randWord();
      addStep(axWrite, regByteAddr(r), model[r], 4'hf, respOkay, '0);
    end
    addStep(axWrite, regByteAddr(0), randWord(), 4'hf, respOkay, '0);
    for (int r = 0; r < 32; r++) begin
      addStep(axRead, regByteAddr(r), '0, 4'hf, respOkay, model[r]);
    end
    runSteps();

    // Out of range addresses and partial strobes
    addStep(axWrite, 12'h088, randWord(), 4'hf, respSlvErr, '0);
    addStep(axRead, 12'h088, '0, 4'hf, respSlvErr, '0);
    addStep(axRead, 12'hffc, '0, 4'hf, respSlvErr, '0);
    addStep(axWrite, regByteAddr(5), randWord(), 4'h7, respSlvErr, '0);
    addStep(axWrite, regByteAddr(9), randWord(), 4'h0, respSlvErr, '0);
    addStep(axWrite, ctrlAddr, 32'h0, 4'hf, respOkay, '0);
    addStep(axRead, regByteAddr(5), '0, 4'hf, respOkay, model[5]);
    addStep(axRead, regByteAddr(9), '0, 4'hf, respOkay, model[9]);
    addStep(axStatus, statusAddr, '0, 4'hf, respOkay, makeStatus(1'b0, 1'b0, 1'b0, 0));
    runSteps();

    runSelfTest();

    // Array holds the pattern of the last pass
    for (int r = 1; r < 32; r++) begin
      model[r] = passWord(r, passCount - 1);
    end
    for (int r = 0; r < 32; r++) begin
      addStep(axRead, regByteAddr(r), '0, 4'hf, respOkay, model[r]);
    end
    runSteps();

    runSelfTest();

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// ==== regBistTop.sv ====
//------------------------------------------------
// Register file with built-in self-test
// AXI4-Lite host port, sequencer and checker
//------------------------------------------------

module regBistTop #(
  parameter int passCount = 2
) (
  input  logic                            begintest,
  input  logic                            rstN,
  input  logic                            awvalid,
  input  logic [regBistPkg::axiAddrW-1:0] awaddr,
  output logic                            awready,
  input  logic                            wvalid,
  input  regBistPkg::regDataT             wdata,
  input  logic [3:0]                      wstrb,
  output logic                            wready,
  output logic                            bvalid,
  input  logic                            bready,
  output regBistPkg::axiRespE             bresp,
  input  logic                            arvalid,
  input  logic [regBistPkg::axiAddrW-1:0] araddr,
  output logic                            arready,
  output logic                            rvalid,
  input  logic                            rready,
  output regBistPkg::regDataT             rdata,
  output regBistPkg::axiRespE             rresp
);
  import regBistPkg::*;

  // Client ports into the array
  regPortIf hostPort ();
  regPortIf bistPort ();

  // Self-test handshake
  bistOpS     op;
  logic       bistActive;
  logic       start;
  logic       done;
  logic       passed;
  logic [7:0] failCount;

  axiLiteRegPort axiPort0 (
    .begintest  (begintest),
    .rstN       (rstN),
    .awvalid    (awvalid),
    .awaddr     (awaddr),
    .awready    (awready),
    .wvalid     (wvalid),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .wready     (wready),
    .bvalid     (bvalid),
    .bready     (bready),
    .bresp      (bresp),
    .arvalid    (arvalid),
    .araddr     (araddr),
    .arready    (arready),
    .rvalid     (rvalid),
    .rready     (rready),
    .rdata      (rdata),
    .rresp      (rresp),
    .hostPort   (hostPort.client),
    .bistActive (bistActive),
    .done       (done),
    .passed     (passed),
    .failCount  (failCount),
    .start      (start)
  );

  bistSequencer #(
    .passCount (passCount)
  ) seq0 (
    .begintest  (begintest),
    .rstN       (rstN),
    .start      (start),
    .bistActive (bistActive),
    .op         (op)
  );

  bistChecker chk0 (
    .begintest (begintest),
    .rstN      (rstN),
    .op        (op),
    .bistPort  (bistPort.client),
    .done      (done),
    .passed    (passed),
    .failCount (failCount)
  );

  regFile rf0 (
    .begintest  (begintest),
    .rstN       (rstN),
    .bistActive (bistActive),
    .hostPort   (hostPort.store),
    .bistPort   (bistPort.store)
  );

endmodule

// ==== axiLiteRegPort.sv ====
//------------------------------------------------
// AXI4-Lite slave for the register file
// Decodes the address map, control and status,
// and acts as host client of the array
//------------------------------------------------

module axiLiteRegPort (
  input  logic                                 begintest,
  input  logic                                 rstN,
  input  logic                                 awvalid,
  input  logic [regBistPkg::axiAddrW-1:0]      awaddr,
  output logic                                 awready,
  input  logic                                 wvalid,
  input  regBistPkg::regDataT                  wdata,
  input  logic [3:0]                           wstrb,
  output logic                                 wready,
  output logic                                 bvalid,
  input  logic                                 bready,
  output regBistPkg::axiRespE                  bresp,
  input  logic                                 arvalid,
  input  logic [regBistPkg::axiAddrW-1:0]      araddr,
  output logic                                 arready,
  output logic                                 rvalid,
  input  logic                                 rready,
  output regBistPkg::regDataT                  rdata,
  output regBistPkg::axiRespE                  rresp,
  regPortIf.client                             hostPort,
  input  logic                                 bistActive,
  input  logic                                 done,
  input  logic                                 passed,
  input  logic [7:0]                           failCount,
  output logic                                 start
);
  import regBistPkg::*;

  // Address and data latched on their own
  logic                awHeld;
  logic                wHeld;
  logic [axiAddrW-1:0] awAddrQ;
  regDataT             wDataQ;
  logic [3:0]          wStrbQ;

  logic                awFire;
  logic                wFire;
  logic                arFire;
  logic                doWrite;
  logic [axiAddrW-1:0] wrAddr;
  regDataT             wrData;
  logic                fullStrobe;
  logic                busy;
  logic                doneShown;
  regDataT             statusWord;
  regDataT             rdNext;
  axiRespE             wrResp;
  axiRespE             rdResp;

  // ------------------------------------------------
  // Handshakes
  // ------------------------------------------------

  // No new write while a response is pending
  assign awready = !awHeld && !bvalid;
  assign wready  = !wHeld && !bvalid;
  assign arready = !rvalid;

  assign awFire = awvalid && awready;
  assign wFire  = wvalid && wready;
  assign arFire = arvalid && arready;

  // Write goes ahead once both halves are in
  assign doWrite    = (awHeld || awFire) && (wHeld || wFire);
  assign wrAddr     = awHeld ? awAddrQ : awaddr;
  assign wrData     = wHeld ? wDataQ : wdata;
  assign fullStrobe = (wHeld ? wStrbQ : wstrb) == 4'hf;

  // ------------------------------------------------
  // Decode and status
  // ------------------------------------------------

  // Pending start counts as busy
  assign busy      = bistActive || start;
  assign doneShown = done && !busy;
  assign statusWord = {16'h0, failCount, 5'b0, passed && doneShown, doneShown, busy};

  always_comb begin
    wrResp = respOkay;
    if (!fullStrobe || (wrAddr > statusAddr)) begin
      wrResp = respSlvErr;
    end else if ((wrAddr < ctrlAddr) && busy) begin
      wrResp = respSlvErr;
    end
  end

  always_comb begin
    rdNext = '0;
    rdResp = respOkay;
    if (araddr > statusAddr) begin
      rdResp = respSlvErr;
    end else if (araddr == statusAddr) begin
      rdNext = statusWord;
    end else if (araddr < ctrlAddr) begin
      // Array belongs to the self-test
      if (busy) begin
        rdResp = respSlvErr;
      end else begin
        rdNext = hostPort.rdata1;
      end
    end
  end

  // Host client of the register file
  assign hostPort.wen    = doWrite && (wrResp == respOkay) && (wrAddr < ctrlAddr);
  assign hostPort.waddr  = wrAddr[6:2];
  assign hostPort.wdata  = wrData;
  assign hostPort.raddr1 = araddr[6:2];
  // Second port mirrors the first
  assign hostPort.raddr2 = araddr[6:2];

  // ------------------------------------------------
  // Control state
  // ------------------------------------------------

  always_ff @(posedge begintest) begin
    if (!rstN) begin
      awHeld <= 1'b0;
      wHeld  <= 1'b0;
      bvalid <= 1'b0;
      rvalid <= 1'b0;
      start  <= 1'b0;
    end else begin
      // One-cycle pulse from bit 0 of the control register
      start <= doWrite && (wrResp == respOkay) && (wrAddr == ctrlAddr) && wrData[0] && !busy;
      if (doWrite) begin
        awHeld <= 1'b0;
        wHeld  <= 1'b0;
        bvalid <= 1'b1;
      end else begin
        if (awFire) begin
          awHeld <= 1'b1;
        end
        if (wFire) begin
          wHeld <= 1'b1;
        end
        if (bvalid && bready) begin
          bvalid <= 1'b0;
        end
      end
      if (arFire) begin
        rvalid <= 1'b1;
      end else if (rvalid && rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  // Payload, held steady under back-pressure
  always_ff @(posedge begintest) begin
    if (awFire) begin
      awAddrQ <= awaddr;
    end
    if (wFire) begin
      wDataQ <= wdata;
      wStrbQ <= wstrb;
    end
    if (doWrite) begin
      bresp <= wrResp;
    end
    if (arFire) begin
      rdata <= rdNext;
      rresp <= rdResp;
    end
  end

endmodule

// ==== bistChecker.sv ====
//------------------------------------------------
// Self-test issue and compare stages
// Drives the register file and counts mismatches
//------------------------------------------------

module bistChecker (
  input  logic               begintest,
  input  logic               rstN,
  input  regBistPkg::bistOpS op,
  regPortIf.client           bistPort,
  output logic               done,
  output logic               passed,
  output logic [7:0]         failCount
);
  import regBistPkg::*;

  // Compare stage registers
  logic    cmpValid;
  logic    cmpRead;
  regDataT cap1;
  regDataT cap2;
  regDataT exp1Q;
  regDataT exp2Q;
  logic    mismatch;
  logic    running;

  // ------------------------------------------------
  // Issue stage
  // ------------------------------------------------

  // Hold writes keep enable low
  assign bistPort.wen    = op.valid && ((op.kind == opWrite) || (op.kind == opZeroWrite));
  assign bistPort.waddr  = op.waddr;
  assign bistPort.wdata  = op.wdata;
  assign bistPort.raddr1 = op.raddr1;
  assign bistPort.raddr2 = op.raddr2;

  always_ff @(posedge begintest) begin
    if (!rstN) begin
      cmpValid <= 1'b0;
      cmpRead  <= 1'b0;
    end else begin
      cmpValid <= op.valid;
      cmpRead  <= op.valid && (op.kind == opRead);
    end
  end

  // Captured data with its expected values
  always_ff @(posedge begintest) begin
    cap1  <= bistPort.rdata1;
    cap2  <= bistPort.rdata2;
    exp1Q <= op.exp1;
    exp2Q <= op.exp2;
  end

  // ------------------------------------------------
  // Compare stage
  // ------------------------------------------------

  // Either port off counts once
  assign mismatch = cmpRead && ((cap1 != exp1Q) || (cap2 != exp2Q));

  always_ff @(posedge begintest) begin
    if (!rstN) begin
      running   <= 1'b0;
      done      <= 1'b0;
      passed    <= 1'b0;
      failCount <= '0;
    end else if (op.valid && !running) begin
      // First operation of a new test
      running   <= 1'b1;
      done      <= 1'b0;
      passed    <= 1'b0;
      failCount <= '0;
    end else begin
      if (mismatch && (failCount != 8'hff)) begin
        failCount <= failCount + 8'd1;
      end
      // Last operation leaves compare with nothing behind it
      if (running && cmpValid && !op.valid) begin
        running <= 1'b0;
        done    <= 1'b1;
        passed  <= (failCount == '0) && !mismatch;
      end
    end
  end

endmodule

// ==== bistSequencer.sv ====
//------------------------------------------------
// Self-test sequencer, pipeline stage 1
// Emits write, read, zero and hold operations
// for each pattern pass
//------------------------------------------------

module bistSequencer #(
  parameter int passCount = 2
) (
  input  logic                begintest,
  input  logic                rstN,
  input  logic                start,
  output logic                bistActive,
  output regBistPkg::bistOpS  op
);
  import regBistPkg::*;

  localparam int passW = (passCount > 1) ? $clog2(passCount) : 1;

  bistStateE        state;
  regAddrT          idx;
  regAddrT          descIdx;
  logic             step;
  logic             drainCnt;
  logic [passW-1:0] passIdx;
  regDataT          patIdx;
  regDataT          patDesc;

  // Index zero-extended into each byte, inverted on odd passes
  function automatic regDataT passPattern(regAddrT a, logic inv);
    regDataT base;
    base = {4{3'b000, a}};
    return inv ? ~base : base;
  endfunction

  // Port 2 walks down while port 1 walks up
  assign descIdx = 5'd0 - idx;
  assign patIdx  = passPattern(idx, passIdx[0]);
  assign patDesc = passPattern(descIdx, passIdx[0]);

  always_ff @(posedge begintest) begin
    if (!rstN) begin
      state      <= stIdle;
      idx        <= '0;
      step       <= 1'b0;
      drainCnt   <= 1'b0;
      passIdx    <= '0;
      bistActive <= 1'b0;
      op         <= '0;
    end else begin
      // Bubble unless a phase emits something
      op <= '0;
      case (state)
        stIdle: begin
          if (start) begin
            state      <= stWrite;
            idx        <= 5'd1;
            passIdx    <= '0;
            bistActive <= 1'b1;
          end
        end
        // Fill registers 1 to 31
        stWrite: begin
          op.valid <= 1'b1;
          op.kind  <= opWrite;
          op.waddr <= idx;
          op.wdata <= patIdx;
          idx      <= (idx == 5'd31) ? 5'd1 : idx + 5'd1;
          if (idx == 5'd31) begin
            state <= stRead;
          end
        end
        // Dual-port readback
        stRead: begin
          op.valid  <= 1'b1;
          op.kind   <= opRead;
          op.raddr1 <= idx;
          op.raddr2 <= descIdx;
          op.exp1   <= patIdx;
          op.exp2   <= patDesc;
          idx       <= (idx == 5'd31) ? 5'd1 : idx + 5'd1;
          if (idx == 5'd31) begin
            state <= stZero;
          end
        end
        // All ones at register 0, then read it back as zero
        stZero: begin
          op.valid <= 1'b1;
          step     <= ~step;
          if (!step) begin
            op.kind  <= opZeroWrite;
            op.wdata <= '1;
          end else begin
            op.kind <= opRead;
            state   <= stHold;
            idx     <= 5'd1;
          end
        end
        // Write with enable low, contents must survive
        stHold: begin
          op.valid <= 1'b1;
          step     <= ~step;
          if (!step) begin
            op.kind  <= opHoldWrite;
            op.waddr <= idx;
            op.wdata <= ~patIdx;
          end else begin
            op.kind   <= opRead;
            op.raddr1 <= idx;
            op.raddr2 <= idx;
            op.exp1   <= patIdx;
            op.exp2   <= patIdx;
            idx       <= (idx == 5'd31) ? 5'd1 : idx + 5'd1;
            if ((idx == 5'd31) && (passIdx == passW'(passCount - 1))) begin
              state <= stDone;
            end else if (idx == 5'd31) begin
              passIdx <= passIdx + 1'b1;
              state   <= stWrite;
            end
          end
        end
        // Two cycles for issue and compare to empty
        stDone: begin
          drainCnt <= ~drainCnt;
          if (drainCnt) begin
            bistActive <= 1'b0;
            state      <= stIdle;
          end
        end
        default: state <= stIdle;
      endcase
    end
  end

endmodule

// ==== regFile.sv ====
//------------------------------------------------
// 32x32 register file, two reads and one write
// Register 0 is hardwired to zero, owner chosen
// between host and self-test client
//------------------------------------------------

module regFile (
  input  logic     begintest,
  input  logic     rstN,
  input  logic     bistActive,
  regPortIf.store  hostPort,
  regPortIf.store  bistPort
);
  import regBistPkg::*;

  // Storage for registers 1 to 31 only
  regDataT mem [1:31];

  // Channels of the client that owns the array
  logic    wen;
  regAddrT waddr;
  regDataT wdata;
  regAddrT ra1;
  regAddrT ra2;
  regDataT rd1;
  regDataT rd2;

  // Self-test owns the array while active
  always_comb begin
    if (bistActive) begin
      wen   = bistPort.wen;
      waddr = bistPort.waddr;
      wdata = bistPort.wdata;
      ra1   = bistPort.raddr1;
      ra2   = bistPort.raddr2;
    end else begin
      wen   = hostPort.wen;
      waddr = hostPort.waddr;
      wdata = hostPort.wdata;
      ra1   = hostPort.raddr1;
      ra2   = hostPort.raddr2;
    end
  end

  // Writes to index 0 fall away
  always_ff @(posedge begintest) begin
    if (!rstN) begin
      for (int i = 1; i < 32; i++) begin
        mem[i] <= '0;
      end
    end else if (wen && (waddr != '0)) begin
      mem[waddr] <= wdata;
    end
  end

  // Index 0 reads zero on both ports
  assign rd1 = (ra1 == '0) ? '0 : mem[ra1];
  assign rd2 = (ra2 == '0) ? '0 : mem[ra2];

  // Only the owner sees real data
  assign hostPort.rdata1 = bistActive ? '0 : rd1;
  assign hostPort.rdata2 = bistActive ? '0 : rd2;
  assign bistPort.rdata1 = bistActive ? rd1 : '0;
  assign bistPort.rdata2 = bistActive ? rd2 : '0;

endmodule

// ==== regPortIf.sv ====
//------------------------------------------------
// Register file client port
// One write channel and two combinational reads
//------------------------------------------------

interface regPortIf;
  import regBistPkg::*;

  // Write channel, applied at the clock edge
  logic    wen;
  regAddrT waddr;
  regDataT wdata;

  // Read channels, combinational
  regAddrT raddr1;
  regAddrT raddr2;
  regDataT rdata1;
  regDataT rdata2;

  // Client side drives writes and read addresses
  modport client (
    output wen, waddr, wdata, raddr1, raddr2,
    input  rdata1, rdata2
  );

  // Storage side returns read data
  modport store (
    input  wen, waddr, wdata, raddr1, raddr2,
    output rdata1, rdata2
  );

endinterface

// ==== regBistPkg.sv ====
//------------------------------------------------
// Register file self-test package
// Widths, opcodes, pipeline operation and the
// AXI4-Lite address map
//------------------------------------------------

package regBistPkg;

  // Register index and register word
  typedef logic [4:0]  regAddrT;
  typedef logic [31:0] regDataT;

  // Byte address width on the AXI4-Lite side
  localparam int axiAddrW = 12;

  // Address map, register n sits at byte address 4*n
  localparam logic [axiAddrW-1:0] ctrlAddr   = 12'h080;
  localparam logic [axiAddrW-1:0] statusAddr = 12'h084;

  // Self-test operation opcodes
  typedef enum logic [1:0] {
    opWrite,
    opRead,
    opZeroWrite,
    opHoldWrite
  } bistOpKindE;

  // One operation travelling down the test pipeline
  typedef struct packed {
    logic       valid;
    bistOpKindE kind;
    regAddrT    waddr;
    regDataT    wdata;
    regAddrT    raddr1;
    regAddrT    raddr2;
    regDataT    exp1;
    regDataT    exp2;
  } bistOpS;

  // Sequencer phases
  typedef enum logic [2:0] {
    stIdle,
    stWrite,
    stRead,
    stZero,
    stHold,
    stDone
  } bistStateE;

  // AXI response codes in use
  typedef enum logic [1:0] {
    respOkay   = 2'd0,
    respSlvErr = 2'd2
  } axiRespE;

endpackage
